// File: rtl/keypad_pkg.sv
`default_nettype none

package keypad_pkg;

    // scanner FSM
    typedef enum logic [2:0] {
        IDLE,                // restart the column scan
        SCAN_COL,            // walk the low column until a row answers
        WAIT_STABLE,         // press debounce
        CONFIRM,             // offer the token to the queue
        WAIT_RELEASE,        // key still held
        WAIT_RELEASE_STABLE  // release debounce
    } scan_state_t;

    // what a token carries in its value field
    typedef enum logic [1:0] {
        KIND_DIGIT,  // value is 0..9
        KIND_OP,     // value low bits hold a calc_op_t
        KIND_EQUAL   // value unused
    } key_kind_t;

    localparam int KEY_VALUE_W = 4;

    // pound position, doubles as the "no key" code
    localparam logic [3:0] KEY_NONE = 4'd14;

endpackage

`default_nettype wire

// File: rtl/calc_pkg.sv
`default_nettype none

package calc_pkg;

    // operator codes, same encoding the keypad decode puts in a token
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,  // sign key, acts on the operand only
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } calc_op_t;

    localparam int DATA_W = 16;  // operands and results wrap at this width

    typedef enum logic {
        ENG_READY,  // popping tokens
        ENG_MUL     // shift-add in progress, queue not served
    } eng_state_t;

endpackage

`default_nettype wire

// File: rtl/keypad_scanner.sv
`timescale 1ns/100ps
`default_nettype none

module keypad_scanner
    import keypad_pkg::*;
    import calc_pkg::*;
#(
    parameter int DEBOUNCE_CYCLES = 500000,
    parameter int SCAN_CYCLES     = 50000   // must exceed the synchronizer depth
) (
    input  wire logic                   clk,
    input  wire logic                   nRST,
    input  wire logic [3:0]             RowIn,       // active low, pulled up
    output logic [3:0]                  ColOut,      // one column low
    output logic                        read_input,  // token on offer
    input  wire logic                   key_read,    // queue can take it
    output key_kind_t                   key_kind,
    output logic [KEY_VALUE_W-1:0]      key_value
);

    localparam int SYNC_STAGES = 2;
    localparam int SCAN_W      = $clog2(SCAN_CYCLES + 1);
    localparam int DEB_W       = $clog2(DEBOUNCE_CYCLES + 1);

    scan_state_t       state, next_state;
    logic [3:0]        row_mid, row_sync;  // two-flop synchronizer
    logic [1:0]        col_index;          // column being driven low
    logic [SCAN_W-1:0] scan_timer;
    logic [DEB_W-1:0]  deb_cnt;
    logic [3:0]        enc_pos;            // row*4 + col, live
    logic [3:0]        key_pos;            // position captured at end of press debounce
    logic              key_pressed;
    logic              settled;            // rows now reflect the current column
    logic              scan_done;
    logic              deb_done;
    logic              has_token;          // pound yields nothing

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            row_mid  <= 4'b1111;
            row_sync <= 4'b1111;
        end else begin
            row_mid  <= RowIn;
            row_sync <= row_mid;
        end
    end

    assign key_pressed = ~&row_sync;
    assign settled     = scan_timer >= SCAN_W'(SYNC_STAGES);
    assign scan_done   = scan_timer == SCAN_W'(SCAN_CYCLES - 1);
    assign deb_done    = deb_cnt == DEB_W'(DEBOUNCE_CYCLES - 1);

    // lowest low row wins, no rollover handling
    always_comb begin
        enc_pos = KEY_NONE;
        for (int r = 3; r >= 0; r--) begin
            if (!row_sync[r]) begin
                enc_pos = {r[1:0], col_index};
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                next_state = SCAN_COL;
            end
            SCAN_COL: begin
                if (key_pressed && settled) begin
                    next_state = WAIT_STABLE;
                end
            end
            WAIT_STABLE: begin
                if (!key_pressed) begin
                    next_state = SCAN_COL;  // bounce, keep scanning
                end else if (deb_done) begin
                    next_state = CONFIRM;
                end
            end
            CONFIRM: begin
                if (!has_token || key_read) begin
                    next_state = WAIT_RELEASE;
                end
            end
            WAIT_RELEASE: begin
                if (!key_pressed) begin
                    next_state = WAIT_RELEASE_STABLE;
                end
            end
            WAIT_RELEASE_STABLE: begin
                if (key_pressed) begin
                    next_state = WAIT_RELEASE;  // release bounced
                end else if (deb_done) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state      <= IDLE;
            col_index  <= '0;
            scan_timer <= '0;
            deb_cnt    <= '0;
            key_pos    <= KEY_NONE;
        end else begin
            state   <= next_state;
            deb_cnt <= '0;  // only the debounce states count
            case (state)
                IDLE: begin
                    scan_timer <= '0;  // column kept, rows already idle
                end
                SCAN_COL: begin
                    if (next_state == SCAN_COL) begin
                        if (scan_done) begin
                            scan_timer <= '0;
                            col_index  <= col_index + 2'd1;
                        end else begin
                            scan_timer <= scan_timer + 1'b1;
                        end
                    end
                end
                WAIT_STABLE: begin
                    if (next_state == WAIT_STABLE) begin
                        deb_cnt <= deb_cnt + 1'b1;
                    end
                    if (next_state == CONFIRM) begin
                        key_pos <= enc_pos;
                    end
                end
                WAIT_RELEASE_STABLE: begin
                    if (next_state == WAIT_RELEASE_STABLE) begin
                        deb_cnt <= deb_cnt + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // keypad layout decode
    always_comb begin
        key_kind  = KIND_DIGIT;
        key_value = '0;
        has_token = 1'b1;
        case (key_pos)
            4'd0:  key_value = 4'd1;
            4'd1:  key_value = 4'd2;
            4'd2:  key_value = 4'd3;
            4'd4:  key_value = 4'd4;
            4'd5:  key_value = 4'd5;
            4'd6:  key_value = 4'd6;
            4'd8:  key_value = 4'd7;
            4'd9:  key_value = 4'd8;
            4'd10: key_value = 4'd9;
            4'd13: key_value = 4'd0;
            4'd3: begin
                key_kind  = KIND_OP;
                key_value = {1'b0, OP_ADD};
            end
            4'd7: begin
                key_kind  = KIND_OP;
                key_value = {1'b0, OP_SUB};
            end
            4'd11: begin
                key_kind  = KIND_OP;
                key_value = {1'b0, OP_MUL};
            end
            4'd15: begin
                key_kind  = KIND_OP;
                key_value = {1'b0, OP_NEG};  // sign key
            end
            4'd12: key_kind = KIND_EQUAL;
            KEY_NONE: has_token = 1'b0;
            default: has_token = 1'b0;
        endcase
    end

    assign read_input = (state == CONFIRM) && has_token;

    always_comb begin
        ColOut            = 4'b1111;
        ColOut[col_index] = 1'b0;
    end

    // column stays put from press detection until the scan resumes
    a_col_held: assert property (@(posedge clk) disable iff (!nRST)
        state != SCAN_COL |=> $stable(ColOut));

endmodule

`default_nettype wire

// File: rtl/key_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module key_fifo
    import keypad_pkg::*;
#(
    parameter int FIFO_DEPTH = 4  // power of two, at least 2
) (
    input  wire logic                   clk,
    input  wire logic                   nRST,
    input  wire logic                   read_input,  // scanner offers a token
    input  wire key_kind_t              key_kind,
    input  wire logic [KEY_VALUE_W-1:0] key_value,
    output logic                        key_read,    // not full
    output logic                        tok_avail,   // head entry valid
    output key_kind_t                   tok_kind,
    output logic [KEY_VALUE_W-1:0]      tok_value,
    input  wire logic                   tok_pop
);

    localparam int AW = $clog2(FIFO_DEPTH);

    key_kind_t              kind_mem  [FIFO_DEPTH];
    logic [KEY_VALUE_W-1:0] value_mem [FIFO_DEPTH];
    logic [AW-1:0]          wr_ptr, rd_ptr;  // wrap on their own
    logic [AW:0]            count;
    logic                   full;
    logic                   wr_en;

    assign full      = count[AW];  // count == FIFO_DEPTH
    assign key_read  = !full;
    assign wr_en     = read_input && key_read;
    assign tok_avail = count != '0;
    assign tok_kind  = kind_mem[rd_ptr];   // show head
    assign tok_value = value_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            kind_mem[wr_ptr]  <= key_kind;
            value_mem[wr_ptr] <= key_value;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (tok_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, tok_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // both or neither, level unchanged
            endcase
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!nRST) tok_pop |-> tok_avail);

    // a key refused while full stays on offer unchanged, so nothing is lost
    a_hold_full: assert property (@(posedge clk) disable iff (!nRST)
        read_input && full |=> read_input && $stable(key_kind) && $stable(key_value));

endmodule

`default_nettype wire

// File: rtl/calc_engine.sv
`timescale 1ns/100ps
`default_nettype none

module calc_engine
    import keypad_pkg::*;
    import calc_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   nRST,
    input  wire logic                   tok_avail,
    input  wire key_kind_t              tok_kind,
    input  wire logic [KEY_VALUE_W-1:0] tok_value,
    output logic                        tok_pop,
    output logic [DATA_W-1:0]           result,
    output logic                        result_valid  // one-cycle strobe
);

    localparam int CNT_W = $clog2(DATA_W);

    eng_state_t        state;
    logic [DATA_W-1:0] acc;       // running total, multiplicand while in ENG_MUL
    logic [DATA_W-1:0] operand;   // number being keyed, multiplier while in ENG_MUL
    logic [DATA_W-1:0] prod;
    logic [DATA_W-1:0] prod_sum;  // product after this step
    logic [DATA_W-1:0] folded;    // acc with a non-multiply pending op applied
    logic [CNT_W-1:0]  mul_cnt;
    calc_op_t          pend_op;
    calc_op_t          tok_op;
    calc_op_t          fin_op;    // op to install once the multiply finishes
    logic              fin_equal; // multiply was started by equals
    logic              fold_req;  // token folds the pending op
    logic              mul_start;
    logic              mul_last;
    logic              res_load;

    assign tok_pop   = tok_avail && (state == ENG_READY);  // stall while multiplying
    assign tok_op    = calc_op_t'(tok_value[2:0]);
    assign fold_req  = (tok_kind == KIND_EQUAL) || (tok_kind == KIND_OP && tok_op != OP_NEG);
    assign mul_start = tok_pop && fold_req && (pend_op == OP_MUL);
    assign mul_last  = (state == ENG_MUL) && (mul_cnt == CNT_W'(DATA_W - 1));
    assign prod_sum  = operand[0] ? prod + acc : prod;

    always_comb begin
        case (pend_op)
            OP_ADD:  folded = acc + operand;
            OP_SUB:  folded = acc - operand;
            default: folded = operand;  // nothing pending, first operand
        endcase
    end

    // equals with no multiply reports at once, otherwise at the last step
    assign res_load = (mul_last && fin_equal) ||
                      (tok_pop && tok_kind == KIND_EQUAL && pend_op != OP_MUL);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state        <= ENG_READY;
            acc          <= '0;
            operand      <= '0;
            prod         <= '0;
            mul_cnt      <= '0;
            pend_op      <= OP_NONE;
            fin_op       <= OP_NONE;
            fin_equal    <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= res_load;
            if (state == ENG_MUL) begin
                prod    <= prod_sum;
                acc     <= acc << 1;
                operand <= operand >> 1;
                mul_cnt <= mul_cnt + 1'b1;
                if (mul_last) begin
                    state   <= ENG_READY;
                    operand <= '0;
                    acc     <= fin_equal ? '0 : prod_sum;
                    pend_op <= fin_equal ? OP_NONE : fin_op;
                end
            end else if (mul_start) begin
                state     <= ENG_MUL;
                prod      <= '0;
                mul_cnt   <= '0;
                fin_op    <= tok_op;
                fin_equal <= tok_kind == KIND_EQUAL;
            end else if (tok_pop) begin
                case (tok_kind)
                    KIND_DIGIT: begin
                        // operand*10 + digit, wraps
                        operand <= (operand << 3) + (operand << 1) + DATA_W'(tok_value);
                    end
                    KIND_OP: begin
                        if (tok_op == OP_NEG) begin
                            operand <= -operand;
                        end else begin
                            acc     <= folded;
                            operand <= '0;
                            pend_op <= tok_op;
                        end
                    end
                    default: begin  // equals, result taken below
                        acc     <= '0;
                        operand <= '0;
                        pend_op <= OP_NONE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res_load) begin
            result <= (state == ENG_MUL) ? prod_sum : folded;
        end
    end

    a_single_pulse: assert property (@(posedge clk) disable iff (!nRST)
        result_valid |=> !result_valid);

endmodule

`default_nettype wire

// File: rtl/keypad_calc_top.sv
`timescale 1ns/100ps
`default_nettype none

module keypad_calc_top
    import keypad_pkg::*;
    import calc_pkg::*;
#(
    parameter int DEBOUNCE_CYCLES = 500000,  // 10 ms at 50 MHz
    parameter int SCAN_CYCLES     = 50000,   // 1 ms per column
    parameter int FIFO_DEPTH      = 4
) (
    input  wire logic        clk,
    input  wire logic        nRST,
    input  wire logic [3:0]  RowIn,
    output logic [3:0]       ColOut,
    output logic [DATA_W-1:0] result,
    output logic             result_valid
);

    // scanner to queue
    logic                   read_input;
    logic                   key_read;
    key_kind_t              key_kind;
    logic [KEY_VALUE_W-1:0] key_value;

    // queue to engine
    logic                   tok_avail;
    logic                   tok_pop;
    key_kind_t              tok_kind;
    logic [KEY_VALUE_W-1:0] tok_value;

    keypad_scanner #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
        .SCAN_CYCLES    (SCAN_CYCLES)
    ) keypad_scanner_i (
        .clk       (clk),
        .nRST      (nRST),
        .RowIn     (RowIn),
        .ColOut    (ColOut),
        .read_input(read_input),
        .key_read  (key_read),
        .key_kind  (key_kind),
        .key_value (key_value)
    );

    key_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) key_fifo_i (
        .clk       (clk),
        .nRST      (nRST),
        .read_input(read_input),
        .key_kind  (key_kind),
        .key_value (key_value),
        .key_read  (key_read),
        .tok_avail (tok_avail),
        .tok_kind  (tok_kind),
        .tok_value (tok_value),
        .tok_pop   (tok_pop)
    );

    calc_engine calc_engine_i (
        .clk         (clk),
        .nRST        (nRST),
        .tok_avail   (tok_avail),
        .tok_kind    (tok_kind),
        .tok_value   (tok_value),
        .tok_pop     (tok_pop),
        .result      (result),
        .result_valid(result_valid)
    );

endmodule

`default_nettype wire

// File: tests/keypad_model.sv
`timescale 1ns/100ps
`default_nettype none

// 4x4 matrix keypad with pull-ups, one key at a time
module keypad_model (
    input  wire logic [3:0] col_out,   // scanner columns, one low
    input  wire logic       key_down,  // a key is held
    input  wire logic [3:0] key_pos,   // row*4 + col of the held key
    output logic [3:0]      row_in     // active low rows back to the scanner
);

    logic [1:0] key_row;
    logic [1:0] key_col;

    assign key_row = key_pos[3:2];
    assign key_col = key_pos[1:0];

    always_comb begin
        row_in = 4'b1111;  // pulled up when nothing connects
        if (key_down && !col_out[key_col]) begin
            row_in[key_row] = 1'b0;  // closed switch shorts row to the low column
        end
    end

endmodule

`default_nettype wire

// File: tests/keypad_calc_tb.sv
`timescale 1ns/100ps
`default_nettype none

module keypad_calc_tb
    import keypad_pkg::*;
    import calc_pkg::*;
();

    localparam int KEY_TIMEOUT    = 200;  // cycles for the scanner to take or drop a key
    localparam int RESULT_TIMEOUT = 300;  // cycles for the engine to report

    logic              clk;
    logic              nRST;
    logic [3:0]        row_in;
    logic [3:0]        col_out;
    logic [DATA_W-1:0] result;
    logic              result_valid;
    logic              key_down;
    logic [3:0]        key_pos;
    logic [15:0]       lfsr;
    logic [3:0]        seq_q [$];  // keys of the sequence being built
    logic [15:0]       exp_q [$];  // results still owed by the DUT
    string             cur_name;
    scan_state_t       scan_state;

    keypad_calc_top #(
        .DEBOUNCE_CYCLES(4),
        .SCAN_CYCLES    (3),
        .FIFO_DEPTH     (4)
    ) keypad_calc_top_i (
        .clk         (clk),
        .nRST        (nRST),
        .RowIn       (row_in),
        .ColOut      (col_out),
        .result      (result),
        .result_valid(result_valid)
    );

    keypad_model keypad_model_i (
        .col_out (col_out),
        .key_down(key_down),
        .key_pos (key_pos),
        .row_in  (row_in)
    );

    assign scan_state = keypad_calc_top_i.keypad_scanner_i.state;  // key accept/release handshake

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_equal(input logic [15:0] actual, input logic [15:0] expected,
                               input string msg);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED at %0t ns: %s, got %0d expected %0d",
                               $time, msg, actual, expected));
        end
    endtask

    task automatic wait_cycle;
        @(posedge clk);
        #10;  // stimulus and sampling well clear of the edge
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = (v << 1) | int'(lfsr[0]);  // one step per bit
        end
    endtask

    // left to right evaluation over keypad positions, 16-bit wrap
    function automatic logic [15:0] calc_expect(input logic [3:0] keys [$]);
        logic [15:0] acc;
        logic [15:0] opnd;
        logic [15:0] res;
        calc_op_t    pend;
        acc  = '0;
        opnd = '0;
        res  = '0;
        pend = OP_NONE;
        foreach (keys[i]) begin
            if (keys[i] == 4'd13 || (keys[i][1:0] != 2'd3 && keys[i][3:2] != 2'd3)) begin
                // digit pad is 3x3 counted from 1, zero sits under it
                opnd = opnd * 16'd10;
                if (keys[i] != 4'd13) begin
                    opnd = opnd + 16'(keys[i][3:2] * 3 + keys[i][1:0] + 1);
                end
            end else if (keys[i] == 4'd15) begin
                opnd = -opnd;  // sign
            end else if (keys[i] != 4'd14) begin  // pound ignored
                case (pend)
                    OP_ADD:  acc = acc + opnd;
                    OP_SUB:  acc = acc - opnd;
                    OP_MUL:  acc = acc * opnd;
                    default: acc = opnd;
                endcase
                opnd = '0;
                case (keys[i])
                    4'd3:    pend = OP_ADD;
                    4'd7:    pend = OP_SUB;
                    4'd11:   pend = OP_MUL;
                    default: begin  // equals
                        res  = acc;
                        acc  = '0;
                        pend = OP_NONE;
                    end
                endcase
            end
        end
        return res;
    endfunction

    task automatic press_key(input logic [3:0] pos, input int min_hold);
        int cnt;
        cnt      = 0;
        key_pos  = pos;
        key_down = 1'b1;
        // hold at least min_hold, and until the scanner has moved on to release
        while (cnt < min_hold ||
               !(scan_state == WAIT_RELEASE || scan_state == WAIT_RELEASE_STABLE)) begin
            wait_cycle();
            cnt++;
            if (cnt > min_hold + KEY_TIMEOUT) begin
                fail_run($sformatf("scanner never took key at position %0d", pos));
            end
        end
    endtask

    task automatic release_key(input int min_gap);
        int cnt;
        cnt      = 0;
        key_down = 1'b0;
        while (cnt < min_gap || !(scan_state == IDLE || scan_state == SCAN_COL)) begin
            wait_cycle();
            cnt++;
            if (cnt > min_gap + KEY_TIMEOUT) begin
                fail_run("scanner never finished the release debounce");
            end
        end
    endtask

    // press every queued key, then wait for the engine to report
    task automatic run_sequence(input string name, input int hold, input int gap);
        int cnt;
        cnt      = 0;
        cur_name = name;
        exp_q.push_back(calc_expect(seq_q));
        foreach (seq_q[i]) begin
            press_key(seq_q[i], hold);
            release_key(gap);
        end
        seq_q.delete();
        while (exp_q.size() != 0) begin
            wait_cycle();
            cnt++;
            if (cnt > RESULT_TIMEOUT) begin
                fail_run($sformatf("no result for sequence %s", name));
            end
        end
    endtask

    // compare process, samples on the falling edge where outputs are settled
    initial begin
        forever begin
            @(negedge clk);
            if (nRST && result_valid) begin
                if (exp_q.size() == 0) begin
                    fail_run("result_valid pulsed with no result expected");
                end else begin
                    check_equal(result, exp_q.pop_front(), cur_name);
                end
            end
        end
    end

    initial begin
        int n;
        int v;
        nRST     = 1'b0;
        key_down = 1'b0;
        key_pos  = 4'd0;
        lfsr     = 16'd13736;
        cur_name = "reset";
        repeat (5) @(posedge clk);
        #10 nRST = 1'b1;
        wait_cycle();

        seq_q = '{4'd0, 4'd1, 4'd2, 4'd12};  // 123 =
        run_sequence("digits 123", 2, 2);
        seq_q = '{4'd13, 4'd12};  // 0 =
        run_sequence("digit 0", 2, 2);

        // 12 + 5 x 3 - 4 =, multiply stalls at the minus
        seq_q = '{4'd0, 4'd1, 4'd3, 4'd5, 4'd11, 4'd2, 4'd7, 4'd4, 4'd12};
        run_sequence("chained ops", 2, 2);

        seq_q = '{4'd8, 4'd15, 4'd3, 4'd0, 4'd13, 4'd12};  // 7 sign + 10 =
        run_sequence("sign key", 2, 2);
        seq_q = '{4'd8, 4'd15, 4'd3, 4'd0, 4'd14, 4'd13, 4'd12};  // pound inside 10
        run_sequence("pound mid operand", 2, 2);

        // fast digits right behind the multiply start, queue holds them
        seq_q = '{4'd10, 4'd11, 4'd10, 4'd3, 4'd0, 4'd1, 4'd2, 4'd4, 4'd12};
        run_sequence("back-pressure", 0, 0);

        for (int s = 0; s < 20; s++) begin
            take_bits(3, v);
            n = 2 + v % 6;  // keys before equals, 3..8 in all
            for (int k = 0; k < n; k++) begin
                take_bits(4, v);
                if (v == 12) begin
                    v = 13;  // one equals per sequence
                end
                seq_q.push_back(4'(v));
            end
            seq_q.push_back(4'd12);
            run_sequence($sformatf("random %0d", s), 1, 1);
        end

        // a 50 cycle hold on digit 5 must give 5, never 55
        seq_q = '{4'd5, 4'd12};
        run_sequence("long hold", 50, 2);

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
rtl/keypad_pkg.sv
rtl/calc_pkg.sv
rtl/keypad_scanner.sv
rtl/key_fifo.sv
rtl/calc_engine.sv
rtl/keypad_calc_top.sv
tests/keypad_model.sv
tests/keypad_calc_tb.sv

// File: Makefile
# Verilator build of the keypad calculator testbench
VERILATOR ?= verilator
TOP       ?= keypad_calc_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# status comes from the search for the pass line in the simulator output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
